//--- hw/exe_pkg.sv
package exe_pkg;

    // MIPS32 widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALU_OP_W   = 12;
    localparam int EX_CODE_W  = 5;

    // one-hot alu_op bit positions
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    // cause register ExcCode values, plus a marker for no exception
    localparam logic [EX_CODE_W-1:0] EX_NONE = 5'h1f;
    localparam logic [EX_CODE_W-1:0] EX_ADEL = 5'h04;
    localparam logic [EX_CODE_W-1:0] EX_ADES = 5'h05;
    localparam logic [EX_CODE_W-1:0] EX_OV   = 5'h0c;

    // data sram size code for a word access
    localparam logic [1:0] SIZE_WORD = 2'b10;

    typedef struct packed {
        logic [4:0] rd;
        logic [4:0] sa;
        logic [5:0] funct;
    } rfmt_t;

    // low half of the instruction word, read as I-format or R-format
    typedef union packed {
        logic [15:0] imm;
        rfmt_t       rfmt;
    } imm_field_u;

    typedef struct packed {
        logic lb;
        logic lbu;
        logic lh;
        logic lhu;
        logic lw;
        logic sb;
        logic sh;
        logic sw;
        logic swl;
        logic swr;
    } mem_kind_t;

    typedef struct packed {
        logic mult;
        logic multu;
        logic mthi;
        logic mtlo;
        logic mfhi;
        logic mflo;
    } hilo_op_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rs_value;
        logic [XLEN-1:0]       rt_value;
        imm_field_u            imm;
        logic [ALU_OP_W-1:0]   alu_op;
        logic                  src1_is_sa;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic                  src2_is_uimm;
        logic                  src2_is_8;
        logic                  trap_add;
        logic                  trap_sub;
        logic                  gr_we;
        logic [REG_ADDR_W-1:0] dest;
        mem_kind_t             mem;
        hilo_op_t              hilo;
    } ds_to_es_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       result;
        logic [REG_ADDR_W-1:0] dest;
        logic                  gr_we;
        mem_kind_t             mem;
        logic [1:0]            byte_off;
        logic [EX_CODE_W-1:0]  ex_code;
        logic [XLEN-1:0]       bad_vaddr;
    } es_to_ms_t;

    typedef struct packed {
        logic            wr;
        logic [1:0]      size;
        logic [3:0]      wstrb;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } sram_req_t;

endpackage

//--- hw/exe_alu.sv
`timescale 1ns/1ps

module exe_alu (
    input  logic [exe_pkg::ALU_OP_W-1:0] alu_op,
    input  logic [exe_pkg::XLEN-1:0]     src1,
    input  logic [exe_pkg::XLEN-1:0]     src2,
    output logic [exe_pkg::XLEN-1:0]     result,
    output logic                         add_ov,
    output logic                         sub_ov
);

    localparam int W = exe_pkg::XLEN;

    logic [W-1:0] add_res;
    logic [W-1:0] sub_res;
    logic [W-1:0] slt_res;
    logic [W-1:0] sltu_res;
    logic [W-1:0] and_res;
    logic [W-1:0] nor_res;
    logic [W-1:0] or_res;
    logic [W-1:0] xor_res;
    logic [W-1:0] sll_res;
    logic [W-1:0] srl_res;
    logic [W-1:0] sra_res;
    logic [W-1:0] lui_res;
    logic [4:0]   shamt;

    assign add_res = src1 + src2;
    assign sub_res = src1 - src2;

    assign slt_res  = {{(W-1){1'b0}}, $signed(src1) < $signed(src2)};
    assign sltu_res = {{(W-1){1'b0}}, src1 < src2};

    assign and_res = src1 & src2;
    assign nor_res = ~(src1 | src2);
    assign or_res  = src1 | src2;
    assign xor_res = src1 ^ src2;

    // shift amount on src1, value on src2
    assign shamt   = src1[4:0];
    assign sll_res = src2 << shamt;
    assign srl_res = src2 >> shamt;
    assign sra_res = $signed(src2) >>> shamt;
    assign lui_res = {src2[15:0], 16'b0};

    // same-sign inputs, flipped result sign
    assign add_ov = (src1[W-1] == src2[W-1]) && (add_res[W-1] != src1[W-1]);
    // differing signs, result sign follows src2
    assign sub_ov = (src1[W-1] != src2[W-1]) && (sub_res[W-1] != src1[W-1]);

    // one-hot select
    assign result = ({W{alu_op[exe_pkg::ALU_ADD]}}  & add_res)
                  | ({W{alu_op[exe_pkg::ALU_SUB]}}  & sub_res)
                  | ({W{alu_op[exe_pkg::ALU_SLT]}}  & slt_res)
                  | ({W{alu_op[exe_pkg::ALU_SLTU]}} & sltu_res)
                  | ({W{alu_op[exe_pkg::ALU_AND]}}  & and_res)
                  | ({W{alu_op[exe_pkg::ALU_NOR]}}  & nor_res)
                  | ({W{alu_op[exe_pkg::ALU_OR]}}   & or_res)
                  | ({W{alu_op[exe_pkg::ALU_XOR]}}  & xor_res)
                  | ({W{alu_op[exe_pkg::ALU_SLL]}}  & sll_res)
                  | ({W{alu_op[exe_pkg::ALU_SRL]}}  & srl_res)
                  | ({W{alu_op[exe_pkg::ALU_SRA]}}  & sra_res)
                  | ({W{alu_op[exe_pkg::ALU_LUI]}}  & lui_res);

endmodule

//--- hw/exe_hilo.sv
`timescale 1ns/1ps

module exe_hilo (
    input  logic                     clk,
    input  logic                     reset,
    input  exe_pkg::hilo_op_t        op,
    input  logic                     commit,
    input  logic [exe_pkg::XLEN-1:0] rs_value,
    input  logic [exe_pkg::XLEN-1:0] rt_value,
    output logic [exe_pkg::XLEN-1:0] hilo_value
);

    logic [exe_pkg::XLEN-1:0]   hi;
    logic [exe_pkg::XLEN-1:0]   lo;
    logic [2*exe_pkg::XLEN-1:0] prod_s;
    logic [2*exe_pkg::XLEN-1:0] prod_u;

    // full 64-bit products
    assign prod_s = $signed(rs_value) * $signed(rt_value);
    assign prod_u = rs_value * rt_value;

    // written once, at the edge the instruction leaves
    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (commit) begin
            if (op.mult) begin
                hi <= prod_s[2*exe_pkg::XLEN-1:exe_pkg::XLEN];
                lo <= prod_s[exe_pkg::XLEN-1:0];
            end else if (op.multu) begin
                hi <= prod_u[2*exe_pkg::XLEN-1:exe_pkg::XLEN];
                lo <= prod_u[exe_pkg::XLEN-1:0];
            end else if (op.mthi) begin
                hi <= rs_value;
            end else if (op.mtlo) begin
                lo <= rs_value;
            end
        end
    end

    // read port for mfhi / mflo
    always_comb begin
        if (op.mfhi) begin
            hilo_value = hi;
        end else if (op.mflo) begin
            hilo_value = lo;
        end else begin
            hilo_value = '0;
        end
    end

endmodule

//--- hw/exe_mem_align.sv
`timescale 1ns/1ps

module exe_mem_align (
    input  exe_pkg::mem_kind_t       mem,
    input  logic [exe_pkg::XLEN-1:0] addr,
    input  logic [exe_pkg::XLEN-1:0] rt_value,
    output logic                     adel,
    output logic                     ades,
    output logic [1:0]               byte_off,
    output logic [3:0]               wstrb,
    output logic [exe_pkg::XLEN-1:0] wdata
);

    assign byte_off = addr[1:0];

    // word needs both low bits clear, half needs bit 0 clear
    assign adel = (mem.lw && (byte_off != 2'b00))
               || ((mem.lh || mem.lhu) && byte_off[0]);
    assign ades = (mem.sw && (byte_off != 2'b00))
               || (mem.sh && byte_off[0]);

    always_comb begin
        wstrb = 4'b0000;
        wdata = rt_value;
        if (mem.sb) begin
            wstrb = 4'b0001 << byte_off;
            wdata = {4{rt_value[7:0]}};
        end else if (mem.sh) begin
            wstrb = byte_off[1] ? 4'b1100 : 4'b0011;
            wdata = {2{rt_value[15:0]}};
        end else if (mem.sw) begin
            wstrb = 4'b1111;
            wdata = rt_value;
        end else if (mem.swl) begin
            // upper bytes of rt land at and below the address
            case (byte_off)
                2'b00: begin
                    wstrb = 4'b0001;
                    wdata = {24'b0, rt_value[31:24]};
                end
                2'b01: begin
                    wstrb = 4'b0011;
                    wdata = {16'b0, rt_value[31:16]};
                end
                2'b10: begin
                    wstrb = 4'b0111;
                    wdata = {8'b0, rt_value[31:8]};
                end
                default: begin
                    wstrb = 4'b1111;
                    wdata = rt_value;
                end
            endcase
        end else if (mem.swr) begin
            // lower bytes of rt land at and above the address
            case (byte_off)
                2'b00: begin
                    wstrb = 4'b1111;
                    wdata = rt_value;
                end
                2'b01: begin
                    wstrb = 4'b1110;
                    wdata = {rt_value[23:0], 8'b0};
                end
                2'b10: begin
                    wstrb = 4'b1100;
                    wdata = {rt_value[15:0], 16'b0};
                end
                default: begin
                    wstrb = 4'b1000;
                    wdata = {rt_value[7:0], 24'b0};
                end
            endcase
        end
    end

endmodule

//--- hw/exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
    input  logic                  clk,
    input  logic                  reset,
    // decode side
    input  logic                  ds_to_es_valid,
    input  exe_pkg::ds_to_es_t    ds_to_es,
    output logic                  es_allowin,
    // memory stage side
    input  logic                  ms_allowin,
    output logic                  es_to_ms_valid,
    output exe_pkg::es_to_ms_t    es_to_ms,
    // data sram request
    output logic                  data_sram_en,
    output exe_pkg::sram_req_t    data_sram,
    input  logic                  data_sram_addr_ok
);

    localparam int W = exe_pkg::XLEN;

    logic                            es_valid;
    exe_pkg::ds_to_es_t              ds_r;
    logic                            es_ready_go;
    logic                            es_accept;
    logic                            es_leave;
    logic                            addr_done;

    logic [W-1:0]                    alu_src1;
    logic [W-1:0]                    alu_src2;
    logic [W-1:0]                    alu_result;
    logic                            add_ov;
    logic                            sub_ov;
    logic                            ov_trap;

    logic [W-1:0]                    hilo_value;
    logic                            hilo_commit;

    logic                            adel;
    logic                            ades;
    logic [1:0]                      byte_off;
    logic [3:0]                      wstrb;
    logic [W-1:0]                    wdata;

    logic                            mem_op;
    logic                            is_store;
    logic [exe_pkg::EX_CODE_W-1:0]   ex_code;
    logic                            has_ex;
    logic                            mem_req;

    // handshakes
    assign es_accept      = ds_to_es_valid && es_allowin;
    assign es_ready_go    = mem_req ? ((data_sram_en && data_sram_addr_ok) || addr_done) : 1'b1;
    assign es_allowin     = !es_valid || (es_ready_go && ms_allowin);
    assign es_to_ms_valid = es_valid && es_ready_go;
    assign es_leave       = es_to_ms_valid && ms_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_accept) begin
            ds_r <= ds_to_es;
        end
    end

    // operand selection
    always_comb begin
        if (ds_r.src1_is_sa) begin
            alu_src1 = {{(W-5){1'b0}}, ds_r.imm.rfmt.sa};
        end else if (ds_r.src1_is_pc) begin
            alu_src1 = ds_r.pc;
        end else begin
            alu_src1 = ds_r.rs_value;
        end
    end

    always_comb begin
        if (ds_r.src2_is_uimm) begin
            alu_src2 = {{(W-16){1'b0}}, ds_r.imm.imm};
        end else if (ds_r.src2_is_imm) begin
            alu_src2 = {{(W-16){ds_r.imm.imm[15]}}, ds_r.imm.imm};
        end else if (ds_r.src2_is_8) begin
            alu_src2 = W'(8);
        end else begin
            alu_src2 = ds_r.rt_value;
        end
    end

    exe_alu u_alu (
        .alu_op (ds_r.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result),
        .add_ov (add_ov),
        .sub_ov (sub_ov)
    );

    // ALU result doubles as the memory address
    exe_mem_align u_mem_align (
        .mem      (ds_r.mem),
        .addr     (alu_result),
        .rt_value (ds_r.rt_value),
        .adel     (adel),
        .ades     (ades),
        .byte_off (byte_off),
        .wstrb    (wstrb),
        .wdata    (wdata)
    );

    exe_hilo u_hilo (
        .clk        (clk),
        .reset      (reset),
        .op         (ds_r.hilo),
        .commit     (hilo_commit),
        .rs_value   (ds_r.rs_value),
        .rt_value   (ds_r.rt_value),
        .hilo_value (hilo_value)
    );

    // overflow ranks above load and store address errors
    assign ov_trap = (ds_r.trap_add && add_ov) || (ds_r.trap_sub && sub_ov);

    always_comb begin
        if (ov_trap) begin
            ex_code = exe_pkg::EX_OV;
        end else if (adel) begin
            ex_code = exe_pkg::EX_ADEL;
        end else if (ades) begin
            ex_code = exe_pkg::EX_ADES;
        end else begin
            ex_code = exe_pkg::EX_NONE;
        end
    end

    assign has_ex      = ex_code != exe_pkg::EX_NONE;
    assign hilo_commit = es_leave && !has_ex;

    // memory request control
    assign mem_op   = |ds_r.mem;
    assign is_store = ds_r.mem.sb || ds_r.mem.sh || ds_r.mem.sw || ds_r.mem.swl || ds_r.mem.swr;
    assign mem_req  = es_valid && mem_op && !has_ex;

    // request already taken while ms held us back
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_done <= 1'b0;
        end else if (es_accept) begin
            addr_done <= 1'b0;
        end else if (data_sram_en && data_sram_addr_ok && !ms_allowin) begin
            addr_done <= 1'b1;
        end
    end

    assign data_sram_en = mem_req && !addr_done;

    always_comb begin
        data_sram.wr    = is_store;
        data_sram.size  = exe_pkg::SIZE_WORD;
        data_sram.wstrb = wstrb;
        data_sram.addr  = alu_result;
        data_sram.wdata = wdata;
    end

    // to memory stage
    always_comb begin
        es_to_ms.pc       = ds_r.pc;
        es_to_ms.dest     = ds_r.dest;
        es_to_ms.gr_we    = ds_r.gr_we;
        es_to_ms.mem      = ds_r.mem;
        es_to_ms.byte_off = byte_off;
        es_to_ms.ex_code  = ex_code;
        if (ds_r.hilo.mfhi || ds_r.hilo.mflo) begin
            es_to_ms.result = hilo_value;
        end else begin
            es_to_ms.result = alu_result;
        end
        if (ex_code == exe_pkg::EX_ADEL || ex_code == exe_pkg::EX_ADES) begin
            es_to_ms.bad_vaddr = alu_result;
        end else begin
            es_to_ms.bad_vaddr = '0;
        end
    end

endmodule

//--- verif/exe_stage_tb.sv
`timescale 1ns/1ps

module exe_stage_tb;

    localparam int MAX_ENTRIES      = 64;
    localparam int CYCLES_PER_ENTRY = 50;

    logic               clk;
    logic               reset;
    logic               ds_to_es_valid;
    exe_pkg::ds_to_es_t ds_to_es;
    logic               es_allowin;
    logic               ms_allowin;
    logic               es_to_ms_valid;
    exe_pkg::es_to_ms_t es_to_ms;
    logic               data_sram_en;
    exe_pkg::sram_req_t data_sram;
    logic               data_sram_addr_ok;

    // one slot per trace line
    int                 t_id [MAX_ENTRIES];
    exe_pkg::ds_to_es_t t_in [MAX_ENTRIES];
    logic [31:0]        t_result [MAX_ENTRIES];
    logic [4:0]         t_ex [MAX_ENTRIES];
    logic [1:0]         t_off [MAX_ENTRIES];
    logic               t_req [MAX_ENTRIES];
    logic [3:0]         t_wstrb [MAX_ENTRIES];
    logic [31:0]        t_wdata [MAX_ENTRIES];

    int n_entries    = 0;
    int accept_count = 0;
    int leave_count  = 0;
    int req_seen     = 0;
    int entry_errors = 0;
    int passed       = 0;
    int failed       = 0;
    int stray        = 0;
    int cycles       = 0;
    int cycle_limit  = 0;

    exe_stage exe_stage_i (
        .clk               (clk),
        .reset             (reset),
        .ds_to_es_valid    (ds_to_es_valid),
        .ds_to_es          (ds_to_es),
        .es_allowin        (es_allowin),
        .ms_allowin        (ms_allowin),
        .es_to_ms_valid    (es_to_ms_valid),
        .es_to_ms          (es_to_ms),
        .data_sram_en      (data_sram_en),
        .data_sram         (data_sram),
        .data_sram_addr_ok (data_sram_addr_ok)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // random back-pressure and memory acceptance near 60 percent each
    initial begin
        void'($urandom(32'h7569));
        forever begin
            @(negedge clk);
            ms_allowin        = ($urandom % 100) < 60;
            data_sram_addr_ok = ($urandom % 100) < 60;
        end
    end

    task automatic load_trace();
        int                 fd;
        int                 r;
        string              line;
        int                 id;
        logic [31:0]        pc, rs, rt, res, wdata;
        logic [15:0]        imm;
        logic [11:0]        alu_op;
        logic [7:0]         sel;
        logic [9:0]         mem;
        logic [5:0]         hilo;
        logic [4:0]         dest, ex;
        logic [1:0]         off;
        logic               req;
        logic [3:0]         wstrb;
        exe_pkg::ds_to_es_t e;
        fd = $fopen("verif/exe_trace.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && n_entries < MAX_ENTRIES) begin
                r = $fgets(line, fd);
                if (r > 0 && line[0] != "#") begin
                    r = $sscanf(line, "%d %h %h %h %h %h %b %h %h %h %h %h %h %b %h %h",
                                id, pc, rs, rt, imm, alu_op, sel, mem, hilo, dest,
                                res, ex, off, req, wstrb, wdata);
                    if (r == 16) begin
                        e = '0;
                        e.pc           = pc;
                        e.rs_value     = rs;
                        e.rt_value     = rt;
                        e.imm.imm      = imm;
                        e.alu_op       = alu_op;
                        e.src1_is_sa   = sel[7];
                        e.src1_is_pc   = sel[6];
                        e.src2_is_imm  = sel[5];
                        e.src2_is_uimm = sel[4];
                        e.src2_is_8    = sel[3];
                        e.trap_add     = sel[2];
                        e.trap_sub     = sel[1];
                        e.gr_we        = sel[0];
                        e.dest         = dest;
                        e.mem          = mem;
                        e.hilo         = hilo;
                        t_id[n_entries]     = id;
                        t_in[n_entries]     = e;
                        t_result[n_entries] = res;
                        t_ex[n_entries]     = ex;
                        t_off[n_entries]    = off;
                        t_req[n_entries]    = req;
                        t_wstrb[n_entries]  = wstrb;
                        t_wdata[n_entries]  = wdata;
                        n_entries++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic flag_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("ERR %0t: test %0d %s is %h, expected %h",
                 $time, t_id[leave_count], what, got, exp);
        entry_errors++;
    endtask

    // request fields at the completing edge
    task automatic check_request();
        int   k;
        logic store;
        k = leave_count;
        store = t_in[k].mem.sb || t_in[k].mem.sh || t_in[k].mem.sw
             || t_in[k].mem.swl || t_in[k].mem.swr;
        if (data_sram.wr !== store) flag_mismatch("sram wr", data_sram.wr, store);
        // every access goes out as a full word
        if (data_sram.size !== 2'd2) flag_mismatch("sram size", data_sram.size, 2'd2);
        if (data_sram.addr !== t_result[k]) begin
            flag_mismatch("sram addr", data_sram.addr, t_result[k]);
        end
        if (store && data_sram.wstrb !== t_wstrb[k]) begin
            flag_mismatch("sram wstrb", data_sram.wstrb, t_wstrb[k]);
        end
        if (store && data_sram.wdata !== t_wdata[k]) begin
            flag_mismatch("sram wdata", data_sram.wdata, t_wdata[k]);
        end
        req_seen++;
    endtask

    task automatic check_leave();
        int          k;
        logic [31:0] exp_bad;
        k = leave_count;
        // bad_vaddr only carries the address on an address error
        if (t_ex[k] == exe_pkg::EX_ADEL || t_ex[k] == exe_pkg::EX_ADES) begin
            exp_bad = t_result[k];
        end else begin
            exp_bad = '0;
        end
        if (es_to_ms.pc !== t_in[k].pc) flag_mismatch("pc", es_to_ms.pc, t_in[k].pc);
        if (es_to_ms.result !== t_result[k]) begin
            flag_mismatch("result", es_to_ms.result, t_result[k]);
        end
        if (es_to_ms.ex_code !== t_ex[k]) flag_mismatch("ex_code", es_to_ms.ex_code, t_ex[k]);
        if (es_to_ms.bad_vaddr !== exp_bad) begin
            flag_mismatch("bad_vaddr", es_to_ms.bad_vaddr, exp_bad);
        end
        if (es_to_ms.dest !== t_in[k].dest) flag_mismatch("dest", es_to_ms.dest, t_in[k].dest);
        if (es_to_ms.gr_we !== t_in[k].gr_we) begin
            flag_mismatch("gr_we", es_to_ms.gr_we, t_in[k].gr_we);
        end
        if (es_to_ms.mem !== t_in[k].mem) flag_mismatch("mem", es_to_ms.mem, t_in[k].mem);
        if ((|t_in[k].mem) && es_to_ms.byte_off !== t_off[k]) begin
            flag_mismatch("byte_off", es_to_ms.byte_off, t_off[k]);
        end
        if (req_seen != (t_req[k] ? 1 : 0)) begin
            $display("test %0d made %0d memory requests instead of %0d",
                     t_id[k], req_seen, t_req[k] ? 1 : 0);
            entry_errors++;
        end
        if (entry_errors == 0) begin
            passed++;
            $display("test %0d passed", t_id[k]);
        end else begin
            failed++;
            $display("test %0d failed with %0d errors", t_id[k], entry_errors);
        end
        entry_errors = 0;
        req_seen = 0;
        leave_count++;
    endtask

    // sample at the rising edge, before the DUT registers update
    always @(posedge clk) begin
        if (!reset) begin
            cycles++;
            if (cycles > cycle_limit) begin
                $display("timeout: trace not finished after %0d cycles", cycle_limit);
                $display("Something failed");
                $finish;
            end else begin
                if (leave_count >= accept_count) begin
                    if (es_to_ms_valid || data_sram_en || !es_allowin) begin
                        $display("stage empty at %0t but its outputs show it busy", $time);
                        stray++;
                    end
                end else begin
                    // a busy stage only takes a new instruction as the old one leaves
                    if (es_allowin !== (es_to_ms_valid && ms_allowin)) begin
                        flag_mismatch("es_allowin", es_allowin, es_to_ms_valid && ms_allowin);
                    end
                    if (data_sram_en && data_sram_addr_ok) check_request();
                    if (es_to_ms_valid && ms_allowin) check_leave();
                end
                if (ds_to_es_valid && es_allowin) accept_count++;
            end
        end
    end

    initial begin
        reset             = 1'b1;
        ds_to_es_valid    = 1'b0;
        ds_to_es          = '0;
        ms_allowin        = 1'b0;
        data_sram_addr_ok = 1'b0;
        load_trace();
        cycle_limit = n_entries * CYCLES_PER_ENTRY;
        if (n_entries == 0) begin
            $display("no entry could be read from verif/exe_trace.txt");
            $display("Something failed");
            $finish;
        end else begin
            repeat (3) @(posedge clk);
            @(negedge clk);
            reset = 1'b0;
            for (int i = 0; i < n_entries; i++) begin
                ds_to_es       = t_in[i];
                ds_to_es_valid = 1'b1;
                while (accept_count <= i) @(negedge clk);
                ds_to_es_valid = 1'b0;
                while (leave_count <= i) @(negedge clk);
            end
            $display("%0d tests, %0d passed, %0d failed, %0d stray events",
                     n_entries, passed, failed, stray);
            if (failed == 0 && stray == 0) begin
                $display("Everything OK");
            end else begin
                $display("Something failed");
            end
            $finish;
        end
    end

endmodule

//--- compile.f
hw/exe_pkg.sv
hw/exe_alu.sv
hw/exe_hilo.sv
hw/exe_mem_align.sv
hw/exe_stage.sv
verif/exe_stage_tb.sv

//--- verif/exe_trace.txt
# id pc rs rt imm alu_op sel mem hilo dest | result ex_code byte_off req wstrb wdata
# sel: sa pc imm uimm 8 trap_add trap_sub gr_we; mem and hilo one-hot hex, first field on top
01 bfc00000 00000005 00000003 0000 001 00000001 000 00 02 00000008 1f 0 0 0 00000000
02 bfc00004 00000003 00000005 0000 002 00000001 000 00 02 fffffffe 1f 0 0 0 00000000
03 bfc00008 ffffffff 00000001 0000 004 00000001 000 00 03 00000001 1f 0 0 0 00000000
04 bfc0000c ffffffff 00000001 0000 008 00000001 000 00 03 00000000 1f 0 0 0 00000000
05 bfc00010 f0f0ff00 0ff0f0f0 0000 010 00000001 000 00 04 00f0f000 1f 0 0 0 00000000
06 bfc00014 f0f0ff00 0ff0f0f0 0000 020 00000001 000 00 04 000f000f 1f 0 0 0 00000000
07 bfc00018 12340000 00000000 8765 040 00010001 000 00 05 12348765 1f 0 0 0 00000000
08 bfc0001c 0000ffff 00000000 ff00 080 00010001 000 00 05 000000ff 1f 0 0 0 00000000
09 bfc00020 00000000 0000000f 1900 100 10000001 000 00 03 000000f0 1f 0 0 0 00000000
10 bfc00024 00000000 f0000000 1a02 200 10000001 000 00 03 00f00000 1f 0 0 0 00000000
11 bfc00028 00000000 f0000000 1a03 400 10000001 000 00 03 fff00000 1f 0 0 0 00000000
12 bfc0002c 00000000 00000000 1234 800 00100001 000 00 06 12340000 1f 0 0 0 00000000
13 bfc00030 00000000 00000000 0000 001 01001001 000 00 1f bfc00038 1f 0 0 0 00000000
14 bfc00034 7fffffff 00000001 0000 001 00000101 000 00 07 80000000 0c 0 0 0 00000000
15 bfc00038 80000000 00000001 0000 002 00000011 000 00 07 7fffffff 0c 0 0 0 00000000
16 bfc0003c 7fffffff 00000001 0000 001 00000001 000 00 07 80000000 1f 0 0 0 00000000
17 bfc00040 fffffffe 00000003 0000 000 00000000 000 20 00 00000000 1f 0 0 0 00000000
18 bfc00044 00000000 00000000 0000 000 00000001 000 02 08 ffffffff 1f 0 0 0 00000000
19 bfc00048 00000000 00000000 0000 000 00000001 000 01 08 fffffffa 1f 0 0 0 00000000
20 bfc0004c fffffffe 00000003 0000 000 00000000 000 10 00 00000000 1f 0 0 0 00000000
21 bfc00050 00000000 00000000 0000 000 00000001 000 02 08 00000002 1f 0 0 0 00000000
22 bfc00054 13579bdf 00000000 0000 000 00000000 000 08 00 00000000 1f 0 0 0 00000000
23 bfc00058 2468ace0 00000000 0000 000 00000000 000 04 00 00000000 1f 0 0 0 00000000
24 bfc0005c 00000000 00000000 0000 000 00000001 000 02 09 13579bdf 1f 0 0 0 00000000
25 bfc00060 00000000 00000000 0000 000 00000001 000 01 09 2468ace0 1f 0 0 0 00000000
26 bfc00064 00001008 00000000 fffc 001 00100001 020 00 0a 00001004 1f 0 1 0 00000000
27 bfc00068 00001000 00000000 0002 001 00100001 080 00 0a 00001002 1f 2 1 0 00000000
28 bfc0006c 00002000 112233cc 0001 001 00100000 010 00 00 00002001 1f 1 1 2 cccccccc
29 bfc00070 00002000 112233cc 0003 001 00100000 010 00 00 00002003 1f 3 1 8 cccccccc
30 bfc00074 00002000 1122beef 0002 001 00100000 008 00 00 00002002 1f 2 1 c beefbeef
31 bfc00078 00002000 deadbeef 0004 001 00100000 004 00 00 00002004 1f 0 1 f deadbeef
32 bfc0007c 00002000 a1b2c3d4 0001 001 00100000 002 00 00 00002001 1f 1 1 3 0000a1b2
33 bfc00080 00002000 a1b2c3d4 0003 001 00100000 001 00 00 00002003 1f 3 1 8 d4000000
34 bfc00084 00003000 00000000 0002 001 00100001 020 00 0a 00003002 04 2 0 0 00000000
35 bfc00088 00003000 00000000 0003 001 00100000 008 00 00 00003003 05 3 0 0 00000000
